//--- design/cuckoo_config.svh
// ----------------------------------------------------------------------
// Build-time parameters of the cuckoo hash table.
// Included by the package and by any RTL file that needs a value here.
// ----------------------------------------------------------------------
`ifndef CUCKOO_CONFIG_SVH
`define CUCKOO_CONFIG_SVH

// Entry layout
`define CUCKOO_KEY_W        16
`define CUCKOO_VALUE_W      16

// Table geometry, 64 slots per table
`define CUCKOO_NUM_TABLES   3
`define CUCKOO_DEPTH_LOG2   6
`define CUCKOO_MAX_KICKS    8

// Odd multipliers for the per-table hash
`define CUCKOO_SEED_0       16'h9e37
`define CUCKOO_SEED_1       16'h7f4b
`define CUCKOO_SEED_2       16'hc2b3

// Command codes on the top-level and table ports
`define CUCKOO_CMD_GET      2'd0
`define CUCKOO_CMD_SET      2'd1
`define CUCKOO_CMD_UNSET    2'd2
`define CUCKOO_CMD_CLEAR    2'd3

`endif

//--- design/cuckoo_pkg.sv
// ----------------------------------------------------------------------
// Shared types of the cuckoo hash table: keys, entries, indices and
// the controller FSM encoding. Referenced by scoped names.
// ----------------------------------------------------------------------
`include "cuckoo_config.svh"

package cuckoo_pkg;

    typedef logic [`CUCKOO_KEY_W-1:0]                  key_t;
    typedef logic [`CUCKOO_VALUE_W-1:0]                value_t;
    // Key in the upper half, value in the lower half
    typedef logic [`CUCKOO_KEY_W+`CUCKOO_VALUE_W-1:0]  entry_t;
    typedef logic [1:0]                                command_t;
    typedef logic [`CUCKOO_DEPTH_LOG2-1:0]             addr_t;
    typedef logic [1:0]                                tbl_idx_t;
    typedef logic [3:0]                                kick_cnt_t;

    typedef enum logic [3:0] {
        ST_RESET,
        ST_IDLE,
        ST_CLEAR,
        ST_CLEAR_WAIT,
        ST_CLEAR_STASH,
        ST_CHECK,
        ST_CHECK_WAIT,
        ST_DELETE,
        ST_DELETE_WAIT,
        ST_INSERT,
        ST_INSERT_WAIT,
        ST_INSERT_POP,
        ST_DONE,
        ST_ERROR
    } ctrl_state_t;

endpackage

//--- design/tbl_if.sv
// ----------------------------------------------------------------------
// Request/response link between the controller and the table set.
// The controller drives modport ctrl, the table set modport tables.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

interface tbl_if;

    // Request side
    logic                  req;
    cuckoo_pkg::command_t  command;
    cuckoo_pkg::tbl_idx_t  tbl_idx;
    cuckoo_pkg::key_t      key;
    cuckoo_pkg::entry_t    wr_entry;

    // Response side, slot content before any write
    logic                  rdy;
    logic                  ack;
    logic                  rd_valid;
    cuckoo_pkg::entry_t    rd_entry;

    modport ctrl (
        output req, command, tbl_idx, key, wr_entry,
        input  rdy, ack, rd_valid, rd_entry
    );

    modport tables (
        input  req, command, tbl_idx, key, wr_entry,
        output rdy, ack, rd_valid, rd_entry
    );

endinterface

//--- design/cuckoo_table.sv
// ----------------------------------------------------------------------
// One hash table: multiplicative hash, entry memory and valid bits.
// Accesses ack one cycle after acceptance; CLEAR sweeps every slot.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "cuckoo_config.svh"

module cuckoo_table #(
    parameter cuckoo_pkg::key_t HASH_SEED = `CUCKOO_SEED_0
) (
    input  logic                  clk,
    input  logic                  srst,
    input  logic                  req,
    input  cuckoo_pkg::command_t  command,
    input  cuckoo_pkg::key_t      key,
    input  cuckoo_pkg::entry_t    wr_entry,
    output logic                  rdy,
    output logic                  ack,
    output logic                  rd_valid,
    output cuckoo_pkg::entry_t    rd_entry
);

    localparam int                DEPTH     = 1 << `CUCKOO_DEPTH_LOG2;
    localparam cuckoo_pkg::addr_t LAST_ADDR = cuckoo_pkg::addr_t'(DEPTH - 1);

    cuckoo_pkg::key_t    product;
    cuckoo_pkg::addr_t   addr;
    cuckoo_pkg::addr_t   clr_addr;
    cuckoo_pkg::entry_t  mem [DEPTH];
    logic [DEPTH-1:0]    valid;
    logic                clearing;
    logic                accept;

    // Low word of key * seed; its top bits spread best
    assign product = key * HASH_SEED;
    assign addr    = product[`CUCKOO_KEY_W-1 -: `CUCKOO_DEPTH_LOG2];
    assign accept  = req && rdy;

    // ------------------------------------------------------------------
    // Handshake, valid bits and clear sweep
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rdy      <= 1'b0;
            ack      <= 1'b0;
            clearing <= 1'b0;
            clr_addr <= '0;
            valid    <= '0;
        end else begin
            ack <= 1'b0;
            if (clearing) begin
                valid[clr_addr] <= 1'b0;
                clr_addr        <= clr_addr + 1'b1;
                // Last slot done, release the table
                if (clr_addr == LAST_ADDR) begin
                    clearing <= 1'b0;
                    rdy      <= 1'b1;
                    ack      <= 1'b1;
                end
            end else begin
                rdy <= 1'b1;
                if (accept) begin
                    case (command)
                        `CUCKOO_CMD_CLEAR: begin
                            clearing <= 1'b1;
                            clr_addr <= '0;
                            rdy      <= 1'b0;
                        end
                        `CUCKOO_CMD_SET: begin
                            valid[addr] <= 1'b1;
                            ack         <= 1'b1;
                        end
                        `CUCKOO_CMD_UNSET: begin
                            valid[addr] <= 1'b0;
                            ack         <= 1'b1;
                        end
                        default: ack <= 1'b1;
                    endcase
                end
            end
        end
    end

    // Read before write, so SET returns the old occupant
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_entry <= mem[addr];
            rd_valid <= valid[addr];
            if (command == `CUCKOO_CMD_SET) begin
                mem[addr] <= wr_entry;
            end
        end
    end

endmodule

//--- design/cuckoo_table_set.sv
// ----------------------------------------------------------------------
// All hash tables behind one link. The request goes to the table
// picked by tbl_idx and that table's response is returned.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "cuckoo_config.svh"

module cuckoo_table_set (
    input  logic   clk,
    input  logic   srst,
    tbl_if.tables  tbl
);

    localparam int NUM_TABLES = `CUCKOO_NUM_TABLES;
    localparam cuckoo_pkg::key_t SEEDS [NUM_TABLES] = '{
        `CUCKOO_SEED_0, `CUCKOO_SEED_1, `CUCKOO_SEED_2
    };

    logic                t_req   [NUM_TABLES];
    logic                t_rdy   [NUM_TABLES];
    logic                t_ack   [NUM_TABLES];
    logic                t_valid [NUM_TABLES];
    cuckoo_pkg::entry_t  t_entry [NUM_TABLES];

    for (genvar g = 0; g < NUM_TABLES; g++) begin : g_tbl
        assign t_req[g] = tbl.req && (tbl.tbl_idx == cuckoo_pkg::tbl_idx_t'(g));

        cuckoo_table #(
            .HASH_SEED (SEEDS[g])
        ) u_table (
            .clk      (clk),
            .srst     (srst),
            .req      (t_req[g]),
            .command  (tbl.command),
            .key      (tbl.key),
            .wr_entry (tbl.wr_entry),
            .rdy      (t_rdy[g]),
            .ack      (t_ack[g]),
            .rd_valid (t_valid[g]),
            .rd_entry (t_entry[g])
        );
    end

    // Response mux; an index past the last table reads as idle
    always_comb begin
        tbl.rdy      = 1'b0;
        tbl.ack      = 1'b0;
        tbl.rd_valid = 1'b0;
        tbl.rd_entry = '0;
        for (int i = 0; i < NUM_TABLES; i++) begin
            if (tbl.tbl_idx == cuckoo_pkg::tbl_idx_t'(i)) begin
                tbl.rdy      = t_rdy[i];
                tbl.ack      = t_ack[i];
                tbl.rd_valid = t_valid[i];
                tbl.rd_entry = t_entry[i];
            end
        end
    end

endmodule

//--- design/cuckoo_controller.sv
// ----------------------------------------------------------------------
// Command FSM: lookup over all tables, delete, cuckoo insertion with a
// one-entry stash and a kick limit, and a table-by-table clear.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "cuckoo_config.svh"

module cuckoo_controller (
    input  logic                  clk,
    input  logic                  srst,
    input  logic                  req,
    input  cuckoo_pkg::command_t  command,
    input  cuckoo_pkg::key_t      key,
    input  cuckoo_pkg::value_t    set_value,
    output logic                  rdy,
    output logic                  ack,
    output logic                  err,
    output logic                  found,
    output cuckoo_pkg::value_t    get_value,
    tbl_if.ctrl                   tbl
);

    localparam cuckoo_pkg::tbl_idx_t  LAST_TBL  =
        cuckoo_pkg::tbl_idx_t'(`CUCKOO_NUM_TABLES - 1);
    localparam cuckoo_pkg::kick_cnt_t LAST_KICK =
        cuckoo_pkg::kick_cnt_t'(`CUCKOO_MAX_KICKS - 1);

    cuckoo_pkg::ctrl_state_t  state;
    cuckoo_pkg::ctrl_state_t  nxt_state;

    // Command context
    cuckoo_pkg::command_t  cmd_r;
    cuckoo_pkg::key_t      cur_key;
    cuckoo_pkg::value_t    cur_value;
    logic                  found_r;
    cuckoo_pkg::value_t    value_r;

    // Bubble stash and loop counters
    cuckoo_pkg::entry_t    stash_entry;
    logic                  stash_active;
    cuckoo_pkg::tbl_idx_t  tbl_idx;
    cuckoo_pkg::kick_cnt_t kick_cnt;
    logic                  idx_inc;

    logic                  tbl_req;
    cuckoo_pkg::command_t  tbl_cmd;
    cuckoo_pkg::key_t      rd_key;
    cuckoo_pkg::value_t    rd_value;
    logic                  hit;
    logic                  accept;

    assign rd_key   = tbl.rd_entry[`CUCKOO_VALUE_W +: `CUCKOO_KEY_W];
    assign rd_value = tbl.rd_entry[`CUCKOO_VALUE_W-1:0];
    assign hit      = tbl.rd_valid && (rd_key == cur_key);
    assign accept   = req && rdy;

    // ------------------------------------------------------------------
    // Next state and table request
    // ------------------------------------------------------------------
    always_comb begin
        nxt_state = state;
        tbl_req   = 1'b0;
        tbl_cmd   = `CUCKOO_CMD_GET;
        idx_inc   = 1'b0;
        case (state)
            cuckoo_pkg::ST_RESET: nxt_state = cuckoo_pkg::ST_IDLE;
            cuckoo_pkg::ST_IDLE: begin
                if (req) begin
                    nxt_state = (command == `CUCKOO_CMD_CLEAR) ?
                                cuckoo_pkg::ST_CLEAR : cuckoo_pkg::ST_CHECK;
                end
            end
            cuckoo_pkg::ST_CLEAR: begin
                tbl_req = 1'b1;
                tbl_cmd = `CUCKOO_CMD_CLEAR;
                if (tbl.rdy) nxt_state = cuckoo_pkg::ST_CLEAR_WAIT;
            end
            cuckoo_pkg::ST_CLEAR_WAIT: begin
                if (tbl.ack) begin
                    idx_inc   = 1'b1;
                    nxt_state = (tbl_idx == LAST_TBL) ?
                                cuckoo_pkg::ST_CLEAR_STASH : cuckoo_pkg::ST_CLEAR;
                end
            end
            cuckoo_pkg::ST_CLEAR_STASH: nxt_state = cuckoo_pkg::ST_DONE;
            cuckoo_pkg::ST_CHECK: begin
                tbl_req = 1'b1;
                if (tbl.rdy) nxt_state = cuckoo_pkg::ST_CHECK_WAIT;
            end
            cuckoo_pkg::ST_CHECK_WAIT: begin
                if (tbl.ack) begin
                    if (hit) begin
                        // Index stays on the matching table for a delete
                        if (cmd_r == `CUCKOO_CMD_GET)        nxt_state = cuckoo_pkg::ST_DONE;
                        else if (cmd_r == `CUCKOO_CMD_UNSET) nxt_state = cuckoo_pkg::ST_DELETE;
                        else                                 nxt_state = cuckoo_pkg::ST_ERROR;
                    end else begin
                        // Wraps to table 0 after the last one, ready for insertion
                        idx_inc = 1'b1;
                        if (tbl_idx != LAST_TBL)             nxt_state = cuckoo_pkg::ST_CHECK;
                        else if (cmd_r == `CUCKOO_CMD_GET)   nxt_state = cuckoo_pkg::ST_DONE;
                        else if (cmd_r == `CUCKOO_CMD_SET)   nxt_state = cuckoo_pkg::ST_INSERT;
                        else                                 nxt_state = cuckoo_pkg::ST_ERROR;
                    end
                end
            end
            cuckoo_pkg::ST_DELETE: begin
                tbl_req = 1'b1;
                tbl_cmd = `CUCKOO_CMD_UNSET;
                if (tbl.rdy) nxt_state = cuckoo_pkg::ST_DELETE_WAIT;
            end
            cuckoo_pkg::ST_DELETE_WAIT: begin
                if (tbl.ack) nxt_state = cuckoo_pkg::ST_DONE;
            end
            cuckoo_pkg::ST_INSERT: begin
                tbl_req = 1'b1;
                tbl_cmd = `CUCKOO_CMD_SET;
                if (tbl.rdy) nxt_state = cuckoo_pkg::ST_INSERT_WAIT;
            end
            cuckoo_pkg::ST_INSERT_WAIT: begin
                if (tbl.ack) nxt_state = cuckoo_pkg::ST_INSERT_POP;
            end
            cuckoo_pkg::ST_INSERT_POP: begin
                // Out of kicks: the displaced entry is dropped
                if (!stash_active)           nxt_state = cuckoo_pkg::ST_DONE;
                else if (kick_cnt == LAST_KICK) nxt_state = cuckoo_pkg::ST_ERROR;
                else begin
                    idx_inc   = 1'b1;
                    nxt_state = cuckoo_pkg::ST_INSERT;
                end
            end
            cuckoo_pkg::ST_DONE:  nxt_state = cuckoo_pkg::ST_IDLE;
            cuckoo_pkg::ST_ERROR: nxt_state = cuckoo_pkg::ST_IDLE;
            default:              nxt_state = cuckoo_pkg::ST_RESET;
        endcase
    end

    // ------------------------------------------------------------------
    // State, stash flag and loop counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state        <= cuckoo_pkg::ST_RESET;
            stash_active <= 1'b0;
            found_r      <= 1'b0;
            tbl_idx      <= '0;
            kick_cnt     <= '0;
        end else begin
            state <= nxt_state;
            if (accept) begin
                found_r  <= 1'b0;
                tbl_idx  <= '0;
                kick_cnt <= '0;
            end else if (idx_inc) begin
                tbl_idx <= (tbl_idx == LAST_TBL) ? '0 : tbl_idx + 1'b1;
            end
            if (state == cuckoo_pkg::ST_CHECK_WAIT && tbl.ack && hit) found_r <= 1'b1;
            if (state == cuckoo_pkg::ST_INSERT_WAIT && tbl.ack && tbl.rd_valid) begin
                stash_active <= 1'b1;
            end else if (state == cuckoo_pkg::ST_INSERT_POP ||
                         state == cuckoo_pkg::ST_CLEAR_STASH) begin
                stash_active <= 1'b0;
            end
            if (state == cuckoo_pkg::ST_INSERT_POP && stash_active) kick_cnt <= kick_cnt + 1'b1;
        end
    end

    // Held key/value, result value and stash payload
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_r     <= command;
            cur_key   <= key;
            cur_value <= set_value;
            value_r   <= '0;
        end
        if (state == cuckoo_pkg::ST_CHECK_WAIT && tbl.ack && hit) value_r <= rd_value;
        if (state == cuckoo_pkg::ST_INSERT_WAIT && tbl.ack && tbl.rd_valid) begin
            stash_entry <= tbl.rd_entry;
        end
        // Pop: the displaced entry becomes the one to place next
        if (state == cuckoo_pkg::ST_INSERT_POP && stash_active) begin
            cur_key   <= stash_entry[`CUCKOO_VALUE_W +: `CUCKOO_KEY_W];
            cur_value <= stash_entry[`CUCKOO_VALUE_W-1:0];
        end
    end

    assign rdy       = (state == cuckoo_pkg::ST_IDLE);
    assign ack       = (state == cuckoo_pkg::ST_DONE) || (state == cuckoo_pkg::ST_ERROR);
    assign err       = (state == cuckoo_pkg::ST_ERROR);
    assign found     = found_r;
    assign get_value = value_r;

    assign tbl.req      = tbl_req;
    assign tbl.command  = tbl_cmd;
    assign tbl.tbl_idx  = tbl_idx;
    assign tbl.key      = cur_key;
    assign tbl.wr_entry = {cur_key, cur_value};

endmodule

//--- design/cuckoo_top.sv
// ----------------------------------------------------------------------
// Cuckoo hash table top level with a req/rdy/ack command port.
// Connects the controller to the table set through tbl_if.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cuckoo_top (
    input  logic                  clk,
    input  logic                  srst,
    input  logic                  req,
    input  cuckoo_pkg::command_t  command,
    input  cuckoo_pkg::key_t      key,
    input  cuckoo_pkg::value_t    set_value,
    output logic                  rdy,
    output logic                  ack,
    output logic                  err,
    output logic                  found,
    output cuckoo_pkg::value_t    get_value
);

    tbl_if u_tbl_if ();

    cuckoo_controller u_controller (
        .clk       (clk),
        .srst      (srst),
        .req       (req),
        .command   (command),
        .key       (key),
        .set_value (set_value),
        .rdy       (rdy),
        .ack       (ack),
        .err       (err),
        .found     (found),
        .get_value (get_value),
        .tbl       (u_tbl_if.ctrl)
    );

    cuckoo_table_set u_table_set (
        .clk  (clk),
        .srst (srst),
        .tbl  (u_tbl_if.tables)
    );

endmodule

//--- dv/cuckoo_sva.sv
// ----------------------------------------------------------------------
// Handshake assertions for the cuckoo hash table top level.
// Bound into every cuckoo_top instance.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cuckoo_sva (
    input logic clk,
    input logic srst,
    input logic rdy,
    input logic ack
);

    // Result strobe is a single-cycle pulse
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (srst) ack |=> !ack
    ) else $error("ack stayed high for more than one cycle");

    // No new command can be taken while a result is returned
    rdy_ack_exclusive: assert property (
        @(posedge clk) disable iff (srst) !(rdy && ack)
    ) else $error("rdy and ack high in the same cycle");

    // Quiet handshake while reset is held
    quiet_in_reset: assert property (
        @(posedge clk) (srst && $past(srst)) |-> (!rdy && !ack)
    ) else $error("rdy or ack high during reset");

endmodule

bind cuckoo_top cuckoo_sva u_sva (
    .clk  (clk),
    .srst (srst),
    .rdy  (rdy),
    .ack  (ack)
);

//--- dv/cuckoo_tb.sv
// ----------------------------------------------------------------------
// Testbench for the cuckoo hash table. Replays the command stream of
// the golden file and checks err, found and get_value on every ack.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cuckoo_tb;

    localparam int MAX_LINES       = 128;
    localparam int FIELDS          = 6;
    localparam int CYCLES_PER_LINE = 100;
    localparam int RESET_CYCLES    = 8;

    logic                  clk = 1'b0;
    logic                  srst;
    logic                  req;
    cuckoo_pkg::command_t  command;
    cuckoo_pkg::key_t      key;
    cuckoo_pkg::value_t    set_value;
    logic                  rdy;
    logic                  ack;
    logic                  err;
    logic                  found;
    cuckoo_pkg::value_t    get_value;

    // Word 0 is the line count, then six fields per command
    logic [15:0]  golden [0:FIELDS*MAX_LINES];
    logic [31:0]  lfsr_state  = 32'h93e184cd;
    int           num_lines   = 0;
    int           cycle_limit = RESET_CYCLES + CYCLES_PER_LINE;
    int           cycle_cnt   = 0;

    cuckoo_top uut (
        .clk       (clk),
        .srst      (srst),
        .req       (req),
        .command   (command),
        .key       (key),
        .set_value (set_value),
        .rdy       (rdy),
        .ack       (ack),
        .err       (err),
        .found     (found),
        .get_value (get_value)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%04h, expected 0x%04h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    function automatic int draw_bits(input int n);
        int bits;
        bits = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = (bits << 1) | int'(lfsr_state[0]);
        end
        return bits;
    endfunction

    // Issue one golden line and check the reply on its ack
    task automatic run_command(input int line);
        int base;
        base = 1 + FIELDS * line;
        @(posedge clk);
        req       <= 1'b1;
        command   <= golden[base][1:0];
        key       <= golden[base + 1];
        set_value <= golden[base + 2];
        // Held until the controller is idle
        @(negedge clk);
        while (!rdy) @(negedge clk);
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (!ack) @(negedge clk);
        check_value($sformatf("err of command %0d", line), 16'(err), golden[base + 3]);
        check_value($sformatf("found of command %0d", line), 16'(found), golden[base + 4]);
        check_value($sformatf("get_value of command %0d", line), get_value,
                    golden[base + 5]);
        check_value($sformatf("rdy of command %0d", line), 16'(rdy), 16'h0000);
    endtask

    // ------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            fail_run($sformatf("Timeout: commands not done after %0d cycles", cycle_limit));
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        srst      = 1'b1;
        req       = 1'b0;
        command   = '0;
        key       = '0;
        set_value = '0;
        $readmemh("dv/cuckoo_golden.txt", golden);
        num_lines = int'(golden[0]);
        if (num_lines <= 0 || num_lines > MAX_LINES) begin
            fail_run("The golden file is missing or has no valid command count");
        end
        cycle_limit = RESET_CYCLES + 4 + CYCLES_PER_LINE * num_lines;

        repeat (RESET_CYCLES) @(posedge clk);
        srst <= 1'b0;

        // Idle after reset, before any command
        @(negedge clk);
        while (!rdy) @(negedge clk);
        check_value("ack after reset", 16'(ack), 16'h0000);

        for (int i = 0; i < num_lines; i++) begin
            run_command(i);
            repeat (draw_bits(2)) @(posedge clk);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- dv/cuckoo_golden.txt
// Cuckoo hash table command stream, all fields in hex
// First word: number of command lines that follow
// Columns: command key set_value exp_err exp_found exp_get_value
// Command codes: 0 GET, 1 SET, 2 UNSET, 3 CLEAR
4e
// Lookup miss, then insert and read back
0 1234 0000 0 0 0000
1 0400 a001 0 0 0000
0 0400 0000 0 1 a001
// Duplicate insert, missing delete, delete and read back
1 0400 beef 1 1 a001
2 1234 0000 1 0 0000
1 0800 b002 0 0 0000
2 0800 0000 0 1 b002
0 0800 0000 0 0 0000
1 0c00 c003 0 0 0000
// Twenty-four keys that all hash to slot 0 of table 0
1 7787 1001 0 0 0000
1 ef0e 1002 0 0 0000
1 6695 1003 0 0 0000
1 de1c 1004 0 0 0000
1 55a3 1005 0 0 0000
1 cd2a 1006 0 0 0000
1 44b1 1007 0 0 0000
1 bc38 1008 0 0 0000
1 33bf 1009 0 0 0000
1 ab46 100a 0 0 0000
1 22cd 100b 0 0 0000
1 9a54 100c 0 0 0000
1 11db 100d 0 0 0000
1 8962 100e 0 0 0000
1 00e9 100f 0 0 0000
1 7870 1010 0 0 0000
1 eff7 1011 0 0 0000
1 677e 1012 0 0 0000
1 df05 1013 0 0 0000
1 568c 1014 0 0 0000
1 ce13 1015 0 0 0000
1 459a 1016 0 0 0000
1 bd21 1017 0 0 0000
1 34a8 1018 0 0 0000
0 7787 0000 0 1 1001
0 ef0e 0000 0 1 1002
0 6695 0000 0 1 1003
0 de1c 0000 0 1 1004
0 55a3 0000 0 1 1005
0 cd2a 0000 0 1 1006
0 44b1 0000 0 1 1007
0 bc38 0000 0 1 1008
0 33bf 0000 0 1 1009
0 ab46 0000 0 1 100a
0 22cd 0000 0 1 100b
0 9a54 0000 0 1 100c
0 11db 0000 0 1 100d
0 8962 0000 0 1 100e
0 00e9 0000 0 1 100f
0 7870 0000 0 1 1010
0 eff7 0000 0 1 1011
0 677e 0000 0 1 1012
0 df05 0000 0 1 1013
0 568c 0000 0 1 1014
0 ce13 0000 0 1 1015
0 459a 0000 0 1 1016
0 bd21 0000 0 1 1017
0 34a8 0000 0 1 1018
// Clear, then earlier keys are gone
3 0000 0000 0 0 0000
0 0400 0000 0 0 0000
0 0c00 0000 0 0 0000
0 7787 0000 0 0 0000
0 cd2a 0000 0 0 0000
0 9a54 0000 0 0 0000
0 7870 0000 0 0 0000
0 ce13 0000 0 0 0000
0 34a8 0000 0 0 0000
// Insertion with displacement after the clear
1 7787 2001 0 0 0000
1 ef0e 2002 0 0 0000
1 6695 2003 0 0 0000
1 de1c 2004 0 0 0000
0 7787 0000 0 1 2001
0 ef0e 0000 0 1 2002
0 6695 0000 0 1 2003
0 de1c 0000 0 1 2004
2 ef0e 0000 0 1 2002
0 ef0e 0000 0 0 0000
1 0400 3001 0 0 0000
0 0400 0000 0 1 3001

//--- verilog.f
+incdir+design
design/cuckoo_pkg.sv
design/tbl_if.sv
design/cuckoo_table.sv
design/cuckoo_table_set.sv
design/cuckoo_controller.sv
design/cuckoo_top.sv
dv/cuckoo_sva.sv
dv/cuckoo_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cuckoo hash table testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module cuckoo_tb -f verilog.f -o cuckoo_sim
./obj_dir/cuckoo_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation FAILED"
    exit 1
elif ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"
